// File: sources.f
common/conv_pkg.sv
source/conv_dmem.sv
conv_engine/conv_addr_gen.sv
conv_engine/conv_mac.sv
source/conv_bus_slave.sv
source/conv_accel_top.sv
testbench/conv_accel_checker.sv
testbench/tb_conv_accel.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_conv_accel
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^TB PASSED$$' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_conv_accel.sv
`default_nettype none

module tb_conv_accel;
    import conv_pkg::*;

    // one weight preload plus nine taps per pixel for every run
    localparam int TAP_TOTAL      = 4 * (8 * 8 * 9 + 9) + (4 * 4 * 9 + 9);
    localparam int TIMEOUT_CYCLES = 4 * TAP_TOTAL + 2000;

    logic    clk = 1'b0;
    logic    reset_i;
    wb_req_t bus_i;
    wb_rsp_t bus_o;

    int unsigned lcg_state   = 61917;
    int          cycle_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;
    int          test_errors = 0;
    int          wt_m [9];          // kernel, row major
    int          ifm_m [256];       // input map, row major
    word_t       mem_words [16];

    conv_accel_top #(.MEM_DEPTH(1024), .MAX_FM_DIM(16)) DUT (
        .clk(clk),
        .reset_i(reset_i),
        .bus_i(bus_i),
        .bus_o(bus_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int lcg_small();
        return int'((lcg_next() >> 16) & 32'hff) - 128;  // -128..127
    endfunction

    function automatic bus_addr_t reg_adr(input int idx);
        return {1'b1, addr_t'(idx)};
    endfunction

    function automatic bus_addr_t mem_adr(input int addr);
        return {1'b0, addr_t'(addr)};
    endfunction

    // expected output pixel, taps outside the map are zero
    function automatic int model_pixel(input int n, input int r, input int c);
        int sum;
        int rr;
        int cc;
        sum = 0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                rr = r + i - 1;
                cc = c + j - 1;
                if (rr >= 0 && rr < n && cc >= 0 && cc < n) begin
                    sum += wt_m[i * 3 + j] * ifm_m[rr * n + cc];
                end
            end
        end
        return sum;
    endfunction

    task automatic bus_access(input logic we, input bus_addr_t adr, input word_t wdat,
                              output word_t rdat);
        @(negedge clk);
        bus_i.cyc = 1'b1;
        bus_i.stb = 1'b1;
        bus_i.we  = we;
        bus_i.adr = adr;
        bus_i.dat = wdat;
        do begin
            @(negedge clk);
        end while (!bus_o.ack);
        rdat = bus_o.dat;
        @(negedge clk);  // hold through the ack cycle
        bus_i = '0;
    endtask

    task automatic bus_write(input bus_addr_t adr, input word_t dat);
        word_t unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input bus_addr_t adr, output word_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        assert (act === exp) else begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    // random kernel and map into memory, then the config registers
    task automatic load_conv(input int n, input int wt_ofs, input int ifm_ofs,
                             input int ofm_ofs);
        for (int t = 0; t < 9; t++) begin
            wt_m[t] = lcg_small();
            bus_write(mem_adr(wt_ofs + t), word_t'(wt_m[t]));
        end
        for (int k = 0; k < n * n; k++) begin
            ifm_m[k] = lcg_small();
            bus_write(mem_adr(ifm_ofs + k), word_t'(ifm_m[k]));
        end
        bus_write(reg_adr(REG_FM_DIM), word_t'(n));
        bus_write(reg_adr(REG_WT_OFS), word_t'(wt_ofs));
        bus_write(reg_adr(REG_IFM_OFS), word_t'(ifm_ofs));
        bus_write(reg_adr(REG_OFM_OFS), word_t'(ofm_ofs));
    endtask

    task automatic wait_done();
        word_t status;
        do begin
            bus_read(reg_adr(REG_STATUS), status);
        end while (!status[1]);
    endtask

    task automatic check_ofm(input string name, input int n, input int ofm_ofs);
        word_t rdat;
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                bus_read(mem_adr(ofm_ofs + r * n + c), rdat);
                check_word(name, word_t'(model_pixel(n, r, c)), rdat);
            end
        end
    endtask

    initial begin
        word_t rdat;
        word_t wval;
        reset_i = 1'b1;
        bus_i   = '0;
        repeat (16) @(negedge clk);
        reset_i = 1'b0;

        bus_read(reg_adr(REG_STATUS), rdat);
        check_word("registers", 32'h1, rdat);  // idle, not done
        for (int idx = REG_CTRL; idx <= REG_OFM_OFS; idx++) begin
            if (idx != REG_STATUS) begin
                bus_read(reg_adr(idx), rdat);
                check_word("registers", '0, rdat);
            end
        end
        bus_write(reg_adr(REG_FM_DIM), 32'd13);
        bus_read(reg_adr(REG_FM_DIM), rdat);
        check_word("registers", 32'd13, rdat);
        for (int idx = REG_WT_OFS; idx <= REG_OFM_OFS; idx++) begin
            wval = lcg_next() & 32'h3ff;
            bus_write(reg_adr(idx), wval);
            bus_read(reg_adr(idx), rdat);
            check_word("registers", wval, rdat);
        end
        finish_test("registers");

        for (int k = 0; k < 16; k++) begin
            mem_words[k] = lcg_next();
            bus_write(mem_adr(700 + k), mem_words[k]);
        end
        for (int k = 0; k < 16; k++) begin
            bus_read(mem_adr(700 + k), rdat);
            check_word("memory", mem_words[k], rdat);
        end
        finish_test("memory");

        load_conv(8, 0, 16, 100);
        bus_write(reg_adr(REG_CTRL), 32'h1);
        wait_done();
        check_ofm("conv_8x8", 8, 100);
        bus_read(reg_adr(REG_STATUS), rdat);
        check_word("conv_8x8", 32'h3, rdat);
        finish_test("conv_8x8");

        bus_write(mem_adr(416), 32'hdeadbeef);  // one past the 4x4 output
        load_conv(4, 300, 320, 400);
        bus_write(reg_adr(REG_CTRL), 32'h1);
        wait_done();
        check_ofm("conv_4x4", 4, 400);
        bus_read(mem_adr(416), rdat);
        check_word("conv_4x4", 32'hdeadbeef, rdat);
        finish_test("conv_4x4");

        load_conv(8, 500, 520, 600);
        bus_write(reg_adr(REG_CTRL), 32'h1);
        for (int k = 0; k < 12; k++) begin
            wval = lcg_next();
            bus_write(mem_adr(900 + k), wval);  // competes with write-back
            bus_read(mem_adr(900 + k), rdat);
            check_word("bus_during_run", wval, rdat);
            @(negedge clk);  // seven-cycle step walks across the write-back slot
        end
        wait_done();
        check_ofm("bus_during_run", 8, 600);
        finish_test("bus_during_run");

        // done still set from the previous run
        bus_write(reg_adr(REG_CTRL), 32'h2);
        bus_read(reg_adr(REG_STATUS), rdat);
        check_word("soft_reset", 32'h1, rdat);
        load_conv(8, 0, 16, 100);
        bus_write(reg_adr(REG_CTRL), 32'h1);
        repeat (60) @(negedge clk);
        bus_write(reg_adr(REG_CTRL), 32'h2);
        bus_read(reg_adr(REG_STATUS), rdat);
        check_word("soft_reset", 32'h1, rdat);
        bus_write(reg_adr(REG_CTRL), 32'h1);
        wait_done();
        check_ofm("soft_reset", 8, 100);
        finish_test("soft_reset");

        $display("tests: %0d, checks: %0d, errors: %0d, assertion errors: %0d",
                 test_count, check_count, error_count,
                 DUT.u_bus_slave.u_checker.fail_count);
        if (error_count == 0 && DUT.u_bus_slave.u_checker.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/conv_accel_checker.sv
`default_nettype none

module conv_accel_checker (
    input wire                    clk,
    input wire                    reset_i,
    input wire conv_pkg::wb_req_t bus_i,
    input wire conv_pkg::wb_rsp_t bus_rsp_i,
    input wire                    busy_i,
    input wire                    start_i
);
    int   fail_count = 0;
    logic req;

    assign req = bus_i.cyc && bus_i.stb;

    ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        bus_rsp_i.ack |-> req)
    else begin
        fail_count++;
        $error("ack without cyc and stb");
    end

    ack_single: assert property (@(posedge clk) disable iff (reset_i)
        bus_rsp_i.ack |=> !bus_rsp_i.ack)
    else begin
        fail_count++;
        $error("ack high two cycles running");
    end

    // first reset edge only settles the registers
    reset_quiet: assert property (@(posedge clk)
        (reset_i && $past(reset_i)) |-> !bus_rsp_i.ack && !busy_i && !start_i)
    else begin
        fail_count++;
        $error("ack, busy or start high during reset");
    end

    ack_latency: assert property (@(posedge clk) disable iff (reset_i)
        req && !bus_rsp_i.ack |-> ##[1:3] bus_rsp_i.ack)
    else begin
        fail_count++;
        $error("request waited more than 3 cycles for ack");
    end

endmodule

bind conv_bus_slave conv_accel_checker u_checker (
    .clk(clk),
    .reset_i(reset_i),
    .bus_i(bus_i),
    .bus_rsp_i(bus_o),
    .busy_i(busy_i),
    .start_i(start_o)
);

`default_nettype wire

// File: source/conv_accel_top.sv
`default_nettype none

module conv_accel_top #(
    parameter int MEM_DEPTH  = 1024,
    parameter int MAX_FM_DIM = 16
) (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire conv_pkg::wb_req_t bus_i,
    output conv_pkg::wb_rsp_t      bus_o
);
    import conv_pkg::*;

    addr_t    porta_addr;
    logic     porta_we;
    word_t    porta_wdata;
    word_t    porta_rdata;
    addr_t    rd_addr;
    word_t    rd_data;
    tap_req_t tap;
    out_wr_t  out_wr;
    logic     start;
    logic     soft_rst;
    logic     busy;
    logic     done;
    logic     pipe_empty;
    dim_t     fm_dim;
    addr_t    wt_ofs;
    addr_t    ifm_ofs;
    addr_t    ofm_ofs;

    conv_bus_slave u_bus_slave (
        .clk(clk),                     .reset_i(reset_i),
        .bus_i(bus_i),                 .bus_o(bus_o),
        .wr_i(out_wr),                 .busy_i(busy),
        .done_i(done),                 .porta_rdata_i(porta_rdata),
        .porta_addr_o(porta_addr),     .porta_we_o(porta_we),
        .porta_wdata_o(porta_wdata),   .start_o(start),
        .soft_rst_o(soft_rst),         .fm_dim_o(fm_dim),
        .wt_ofs_o(wt_ofs),             .ifm_ofs_o(ifm_ofs),
        .ofm_ofs_o(ofm_ofs)
    );

    conv_addr_gen #(.MAX_FM_DIM(MAX_FM_DIM)) u_addr_gen (
        .clk(clk),                     .reset_i(reset_i),
        .start_i(start),               .soft_rst_i(soft_rst),
        .fm_dim_i(fm_dim),             .wt_ofs_i(wt_ofs),
        .ifm_ofs_i(ifm_ofs),           .ofm_ofs_i(ofm_ofs),
        .pipe_empty_i(pipe_empty),     .rd_addr_o(rd_addr),
        .tap_o(tap),                   .busy_o(busy),
        .done_o(done)
    );

    conv_mac u_mac (
        .clk(clk),                     .reset_i(reset_i),
        .soft_rst_i(soft_rst),         .tap_i(tap),
        .rd_data_i(rd_data),           .wr_o(out_wr),
        .pipe_empty_o(pipe_empty)
    );

    conv_dmem #(.MEM_DEPTH(MEM_DEPTH)) u_dmem (
        .clk(clk),
        .a_addr_i(porta_addr),         .a_we_i(porta_we),
        .a_wdata_i(porta_wdata),       .b_addr_i(rd_addr),
        .a_rdata_o(porta_rdata),       .b_rdata_o(rd_data)
    );

endmodule

`default_nettype wire

// File: source/conv_bus_slave.sv
`default_nettype none

module conv_bus_slave (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire conv_pkg::wb_req_t  bus_i,
    input  wire conv_pkg::out_wr_t  wr_i,
    input  wire                     busy_i,
    input  wire                     done_i,
    input  wire conv_pkg::word_t    porta_rdata_i,
    output conv_pkg::wb_rsp_t       bus_o,
    output conv_pkg::addr_t         porta_addr_o,
    output logic                    porta_we_o,
    output conv_pkg::word_t         porta_wdata_o,
    output logic                    start_o,
    output logic                    soft_rst_o,
    output conv_pkg::dim_t          fm_dim_o,
    output conv_pkg::addr_t         wt_ofs_o,
    output conv_pkg::addr_t         ifm_ofs_o,
    output conv_pkg::addr_t         ofm_ofs_o
);
    import conv_pkg::*;

    logic       req;
    logic       reg_sel;
    logic       reg_acc;
    logic       mem_acc;
    logic [2:0] reg_idx;
    logic       ack_q;
    logic       mem_rd_q;      // acked access was a memory read
    logic       done_q;
    word_t      reg_rdata;
    word_t      reg_rdata_q;

    assign req     = bus_i.cyc && bus_i.stb && !ack_q;  // no restart in the ack cycle
    assign reg_sel = bus_i.adr[REG_SPACE_BIT];
    assign reg_acc = req && reg_sel;
    assign mem_acc = req && !reg_sel && !wr_i.valid;    // engine write wins port A
    assign reg_idx = bus_i.adr[2:0];

    assign porta_we_o    = wr_i.valid || (mem_acc && bus_i.we);
    assign porta_addr_o  = wr_i.valid ? wr_i.addr : bus_i.adr[ADDR_W-1:0];
    assign porta_wdata_o = wr_i.valid ? wr_i.data : bus_i.dat;

    assign bus_o.ack = ack_q;
    assign bus_o.dat = mem_rd_q ? porta_rdata_i : reg_rdata_q;

    always_comb begin
        case (reg_idx)
            REG_STATUS:  reg_rdata = {30'b0, done_q, !busy_i};
            REG_FM_DIM:  reg_rdata = word_t'(fm_dim_o);
            REG_WT_OFS:  reg_rdata = word_t'(wt_ofs_o);
            REG_IFM_OFS: reg_rdata = word_t'(ifm_ofs_o);
            REG_OFM_OFS: reg_rdata = word_t'(ofm_ofs_o);
            default:     reg_rdata = '0;  // ctrl reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        reg_rdata_q <= reg_rdata;
        if (reset_i) begin
            ack_q      <= 1'b0;
            mem_rd_q   <= 1'b0;
            done_q     <= 1'b0;
            start_o    <= 1'b0;
            soft_rst_o <= 1'b0;
            fm_dim_o   <= '0;
            wt_ofs_o   <= '0;
            ifm_ofs_o  <= '0;
            ofm_ofs_o  <= '0;
        end else begin
            ack_q      <= reg_acc || mem_acc;
            mem_rd_q   <= mem_acc && !bus_i.we;
            start_o    <= 1'b0;
            soft_rst_o <= 1'b0;
            if (reg_acc && bus_i.we) begin
                case (reg_idx)
                    REG_CTRL: begin
                        start_o    <= bus_i.dat[0];
                        soft_rst_o <= bus_i.dat[1];
                    end
                    REG_FM_DIM:  fm_dim_o  <= bus_i.dat[4:0];
                    REG_WT_OFS:  wt_ofs_o  <= bus_i.dat[ADDR_W-1:0];
                    REG_IFM_OFS: ifm_ofs_o <= bus_i.dat[ADDR_W-1:0];
                    REG_OFM_OFS: ofm_ofs_o <= bus_i.dat[ADDR_W-1:0];
                    default: ;
                endcase
            end
            if (done_i) begin
                done_q <= 1'b1;
            end
            if (start_o || soft_rst_o) begin
                done_q <= 1'b0;  // clear beats a coincident done
            end
        end
    end

endmodule

`default_nettype wire

// File: conv_engine/conv_mac.sv
`default_nettype none

module conv_mac (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     soft_rst_i,
    input  wire conv_pkg::tap_req_t tap_i,
    input  wire conv_pkg::word_t    rd_data_i,
    output conv_pkg::out_wr_t       wr_o,
    output logic                    pipe_empty_o
);
    import conv_pkg::*;

    tap_req_t tap_q;       // lines up with the memory read data
    word_t    wt_q [9];
    word_t    prod_q;
    word_t    acc_q;
    word_t    sum;
    logic     mul_vld_q;
    logic     mul_last_q;
    addr_t    mul_addr_q;

    assign sum          = acc_q + prod_q;
    assign pipe_empty_o = !(tap_q.valid || mul_vld_q || wr_o.valid);

    always_ff @(posedge clk) begin
        tap_q <= tap_i;
        if (reset_i || soft_rst_i) begin
            tap_q.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tap_q.valid && tap_q.is_weight) begin
            wt_q[tap_q.tap] <= rd_data_i;
        end
    end

    // multiply, low 32 bits match for signed operands
    always_ff @(posedge clk) begin
        prod_q     <= wt_q[tap_q.tap] * (tap_q.pad ? '0 : rd_data_i);
        mul_last_q <= tap_q.last;
        mul_addr_q <= tap_q.out_addr;
        if (reset_i || soft_rst_i) begin
            mul_vld_q <= 1'b0;
        end else begin
            mul_vld_q <= tap_q.valid && !tap_q.is_weight;
        end
    end

    // accumulate, emit the sum on the pixel's last tap
    always_ff @(posedge clk) begin
        wr_o.addr <= mul_addr_q;
        wr_o.data <= sum;
        if (reset_i || soft_rst_i) begin
            acc_q      <= '0;
            wr_o.valid <= 1'b0;
        end else begin
            wr_o.valid <= mul_vld_q && mul_last_q;
            if (mul_vld_q) begin
                acc_q <= mul_last_q ? '0 : sum;
            end
        end
    end

endmodule

`default_nettype wire

// File: conv_engine/conv_addr_gen.sv
`default_nettype none

module conv_addr_gen #(
    parameter int MAX_FM_DIM = 16
) (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     start_i,
    input  wire                     soft_rst_i,
    input  wire conv_pkg::dim_t     fm_dim_i,
    input  wire conv_pkg::addr_t    wt_ofs_i,
    input  wire conv_pkg::addr_t    ifm_ofs_i,
    input  wire conv_pkg::addr_t    ofm_ofs_i,
    input  wire                     pipe_empty_i,
    output conv_pkg::addr_t         rd_addr_o,
    output conv_pkg::tap_req_t      tap_o,
    output logic                    busy_o,
    output logic                    done_o
);
    import conv_pkg::*;

    engine_state_t state_q;
    dim_t          fm;
    dim_t          row_q;
    dim_t          col_q;
    logic [1:0]    ti_q;         // kernel row
    logic [1:0]    tj_q;         // kernel column
    tap_t          tap_q;
    addr_t         out_addr_q;
    logic [5:0]    rr;           // input row plus one
    logic [5:0]    cc;           // input column plus one
    logic          pad;
    logic          last_tap;
    logic          is_wt;
    logic          issue;
    addr_t         tap_addr;

    assign fm       = (fm_dim_i > dim_t'(MAX_FM_DIM)) ? dim_t'(MAX_FM_DIM) : fm_dim_i;
    assign rr       = {1'b0, row_q} + 6'(ti_q);
    assign cc       = {1'b0, col_q} + 6'(tj_q);
    assign pad      = (rr == '0) || (cc == '0) || (rr > {1'b0, fm}) || (cc > {1'b0, fm});
    assign last_tap = (tap_q == tap_t'(8));
    assign tap_addr = ifm_ofs_i + addr_t'(rr - 6'd1) * addr_t'(fm) + addr_t'(cc - 6'd1);

    // weight tap 0 goes out in the same cycle start is seen
    assign is_wt = (state_q == IDLE) || (state_q == LOAD_WT);
    assign issue = ((state_q == IDLE) && start_i) || (state_q == LOAD_WT) || (state_q == CONV);

    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == DONE);

    always_ff @(posedge clk) begin
        rd_addr_o       <= is_wt ? wt_ofs_i + addr_t'(tap_q) : tap_addr;
        tap_o.pad       <= !is_wt && pad;
        tap_o.is_weight <= is_wt;
        tap_o.last      <= !is_wt && last_tap;
        tap_o.tap       <= tap_q;
        tap_o.out_addr  <= out_addr_q;
        if (reset_i || soft_rst_i) begin
            state_q     <= IDLE;
            tap_q       <= '0;
            ti_q        <= '0;
            tj_q        <= '0;
            row_q       <= '0;
            col_q       <= '0;
            tap_o.valid <= 1'b0;
        end else begin
            tap_o.valid <= issue;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q    <= LOAD_WT;
                        tap_q      <= tap_t'(1);
                        out_addr_q <= ofm_ofs_i;
                    end
                end
                LOAD_WT: begin
                    tap_q <= tap_q + 1'b1;
                    if (last_tap) begin
                        tap_q   <= '0;
                        state_q <= (fm == '0) ? DRAIN : CONV;  // empty map has no pixels
                    end
                end
                CONV: begin
                    if (last_tap) begin
                        tap_q      <= '0;
                        ti_q       <= '0;
                        tj_q       <= '0;
                        out_addr_q <= out_addr_q + 1'b1;
                        if (col_q == fm - 1'b1) begin
                            col_q <= '0;
                            if (row_q == fm - 1'b1) begin
                                row_q   <= '0;
                                state_q <= DRAIN;
                            end else begin
                                row_q <= row_q + 1'b1;
                            end
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end else begin
                        tap_q <= tap_q + 1'b1;
                        if (tj_q == 2'd2) begin
                            tj_q <= '0;
                            ti_q <= ti_q + 1'b1;
                        end else begin
                            tj_q <= tj_q + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    if (pipe_empty_i && !tap_o.valid) begin  // last write has gone out
                        state_q <= DONE;
                    end
                end
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/conv_dmem.sv
`default_nettype none

module conv_dmem #(
    parameter int MEM_DEPTH = 1024
) (
    input  wire                  clk,
    input  wire conv_pkg::addr_t a_addr_i,
    input  wire                  a_we_i,
    input  wire conv_pkg::word_t a_wdata_i,
    input  wire conv_pkg::addr_t b_addr_i,
    output conv_pkg::word_t      a_rdata_o,
    output conv_pkg::word_t      b_rdata_o
);
    import conv_pkg::*;

    word_t mem [MEM_DEPTH];

    // port A, bus and engine write-back
    always_ff @(posedge clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;
        end
        a_rdata_o <= mem[a_addr_i];  // old data on a same-cycle write
    end

    // port B, engine tap reads only
    always_ff @(posedge clk) begin
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

`default_nettype wire

// File: common/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int WORD_W = 32;
    localparam int ADDR_W = 10;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [3:0]        tap_t;       // 0..8 inside the 3x3 kernel
    typedef logic [4:0]        dim_t;
    typedef logic [ADDR_W:0]   bus_addr_t;  // memory space plus register space bit

    // register word indices
    localparam int REG_CTRL    = 0;
    localparam int REG_STATUS  = 1;
    localparam int REG_FM_DIM  = 2;
    localparam int REG_WT_OFS  = 3;
    localparam int REG_IFM_OFS = 4;
    localparam int REG_OFM_OFS = 5;

    localparam int REG_SPACE_BIT = ADDR_W;  // set selects registers

    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        bus_addr_t adr;
        word_t     dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  pad;        // tap outside the map, counts as zero
        logic  is_weight;
        logic  last;       // tap 8 of a pixel
        tap_t  tap;
        addr_t out_addr;
    } tap_req_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        word_t data;
    } out_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_WT,
        CONV,
        DRAIN,
        DONE
    } engine_state_t;

endpackage

`default_nettype wire
